// File: src/vgc_timing_pkg.sv
package vgc_timing_pkg;

    // Raster coordinates and video memory words
    typedef logic [9:0]  hpos_t;
    typedef logic [8:0]  vpos_t;
    typedef logic [22:0] vaddr_t;
    typedef logic [7:0]  vbyte_t;

    // Phase of the per-line fetch sequence
    typedef enum logic [2:0] {
        IDLE,
        SCB_ADDR,
        SCB_LATCH,
        PAL_FETCH,
        PIX_FETCH
    } line_phase_e;

    // One strobe per fetch action, at most one high per pixel strobe
    typedef struct packed {
        logic load_scb_addr;
        logic latch_scb;
        logic load_pal_base;
        logic load_line_base;
        logic pal_step;
        logic pix_step;
    } fetch_ctl_t;

    // Horizontal fetch positions
    localparam hpos_t SCB_ADDR_H      = 10'd908;
    localparam hpos_t SCB_LATCH_H     = 10'd910;
    localparam hpos_t PAL_START_H     = 10'd912;
    localparam hpos_t PAL_END_H       = 10'd32;
    localparam hpos_t PIX_END_H       = 10'd672;
    localparam hpos_t PIX_LAST_STEP_H = 10'd668;

    // Vertical positions of the SHR window and interrupts
    localparam vpos_t FIRST_LINE_V = 9'd32;
    localparam vpos_t LAST_LINE_V  = 9'd232;
    localparam vpos_t IRQ_FIRST_V  = 9'd31;
    localparam vpos_t IRQ_END_V    = 9'd206;
    localparam vpos_t VBL_V        = 9'd199;

    // Offsets inside the SHR buffer
    localparam vaddr_t SCB_OFFSET = 23'h007D00;
    localparam vaddr_t PAL_OFFSET = 23'h007E00;
    localparam vaddr_t LINE_BYTES = 23'd160;

endpackage

// File: src/vgc_color_pkg.sv
package vgc_color_pkg;

    // One 4-bit color channel
    typedef logic [3:0] nib_t;

    // Index into a 16-entry palette
    typedef logic [3:0] pal_idx_t;

    // IIgs native color, four bits per channel
    typedef struct packed {
        nib_t r;
        nib_t g;
        nib_t b;
    } rgb12_t;

    // Display color, eight bits per channel
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb24_t;

    // Fixed IIgs colors used for the border
    localparam rgb12_t BORDER_PALETTE [16] = '{
        12'h000,  // Black
        12'hd03,  // Deep red
        12'h009,  // Dark blue
        12'hd2d,  // Purple
        12'h072,  // Dark green
        12'h555,  // Dark gray
        12'h22f,  // Medium blue
        12'h6af,  // Light blue
        12'h850,  // Brown
        12'hf60,  // Orange
        12'haaa,  // Light gray
        12'hf98,  // Pink
        12'h1d0,  // Light green
        12'hff0,  // Yellow
        12'h4f9,  // Aquamarine
        12'hfff   // White
    };

endpackage

// File: src/shr_line_sequencer.sv
`timescale 1ns/1ps

module shr_line_sequencer import vgc_timing_pkg::*; (
    input  logic       clk_vid,
    input  logic       rst,
    input  logic       ce_pix,
    input  hpos_t      h,
    input  vpos_t      v,
    input  logic       shr_enable,
    output fetch_ctl_t fctl,
    output logic       vbl_irq
);

    line_phase_e state;
    line_phase_e state_next;
    fetch_ctl_t  ctl;
    logic        fetch_line;
    logic        in_vbl;
    logic        in_vbl_d;

    // SCB for line V+1 is read on line V, so fetch starts one line early
    assign fetch_line = shr_enable
                     && v >= vpos_t'(FIRST_LINE_V - 1)
                     && v <  vpos_t'(LAST_LINE_V - 1);

    always_comb begin
        state_next = state;
        ctl        = '0;
        case (state)
            IDLE: begin
                if (h == SCB_ADDR_H && fetch_line) begin
                    ctl.load_scb_addr = 1'b1;
                    state_next        = SCB_ADDR;
                end
            end
            SCB_ADDR: begin
                if (h == SCB_LATCH_H) begin
                    ctl.latch_scb = 1'b1;
                    state_next    = SCB_LATCH;
                end
            end
            SCB_LATCH: begin
                if (h == PAL_START_H) begin
                    ctl.load_pal_base = 1'b1;
                    state_next        = PAL_FETCH;
                end
            end
            PAL_FETCH: begin
                // H wraps to 0 here, palette bytes arrive on H=0..31
                if (h == hpos_t'(PAL_END_H - 1)) begin
                    ctl.load_line_base = 1'b1;
                    state_next         = PIX_FETCH;
                end else if (h < hpos_t'(PAL_END_H - 1)) begin
                    ctl.pal_step = 1'b1;
                end
            end
            PIX_FETCH: begin
                // No address step once the last byte is on the bus
                if (h < PIX_LAST_STEP_H) begin
                    ctl.pix_step = 1'b1;
                end
                if (h == hpos_t'(PIX_END_H - 1)) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // Strobes last exactly one pixel clock
    assign fctl = ce_pix ? ctl : '0;

    always_ff @(posedge clk_vid) begin
        if (rst) begin
            state <= IDLE;
        end else if (ce_pix) begin
            state <= state_next;
        end
    end

    // Blank level and its delayed copy give a single-strobe edge pulse
    assign in_vbl = v >= VBL_V;

    always_ff @(posedge clk_vid) begin
        if (rst) begin
            // Held high so no pulse fires if reset ends inside blanking
            in_vbl_d <= 1'b1;
        end else if (ce_pix) begin
            in_vbl_d <= in_vbl;
        end
    end

    assign vbl_irq = ce_pix && in_vbl && !in_vbl_d;

endmodule

// File: src/shr_fetch_addr.sv
`timescale 1ns/1ps

module shr_fetch_addr import vgc_timing_pkg::*, vgc_color_pkg::*; #(
    parameter vaddr_t BUF_BASE = 23'h012000
) (
    input  logic       clk_vid,
    input  logic       rst,
    input  logic       ce_pix,
    input  fetch_ctl_t fctl,
    input  vpos_t      v,
    input  pal_idx_t   scb_bank,
    output vaddr_t     video_addr,
    output logic [1:0] byte_phase
);

    vaddr_t scb_addr;
    vaddr_t pal_addr;
    vaddr_t line_addr;
    logic   addr_step;

    // SCB entry for the line that follows the current one
    assign scb_addr = BUF_BASE + SCB_OFFSET + vaddr_t'(v - FIRST_LINE_V + 9'd1);

    // 16 entries of two bytes each per palette
    assign pal_addr = BUF_BASE + PAL_OFFSET + {14'd0, scb_bank, 5'd0};

    // Start of the pixel row for this line
    assign line_addr = BUF_BASE + LINE_BYTES * vaddr_t'(v - FIRST_LINE_V);

    // Palette bytes are consecutive, pixel bytes advance once per four strobes
    assign addr_step = fctl.load_pal_base
                    || fctl.pal_step
                    || (fctl.pix_step && byte_phase == 2'd2);

    always_ff @(posedge clk_vid) begin
        if (rst) begin
            video_addr <= '0;
            byte_phase <= '0;
        end else if (ce_pix) begin
            // Free-running phase, aligned to byte 0 at the line base load
            if (fctl.load_line_base) begin
                byte_phase <= '0;
            end else begin
                byte_phase <= byte_phase + 2'd1;
            end

            if (fctl.load_scb_addr) begin
                video_addr <= scb_addr;
            end else if (fctl.latch_scb) begin
                video_addr <= pal_addr;
            end else if (fctl.load_line_base) begin
                video_addr <= line_addr;
            end else if (addr_step) begin
                video_addr <= video_addr + 23'd1;
            end
        end
    end

endmodule

// File: src/shr_palette.sv
`timescale 1ns/1ps

module shr_palette import vgc_timing_pkg::*, vgc_color_pkg::*; (
    input  logic       clk_vid,
    input  logic       rst,
    input  logic       ce_pix,
    input  fetch_ctl_t fctl,
    input  logic       addr_odd,
    input  vbyte_t     video_data,
    input  pal_idx_t   rd_idx,
    output rgb12_t     rd_rgb
);

    rgb12_t   pal_mem [16];
    pal_idx_t wr_idx;
    logic     wr_en;

    // Last R byte lands on the same strobe as the line base load
    assign wr_en = fctl.pal_step || fctl.load_line_base;

    always_ff @(posedge clk_vid) begin
        if (rst) begin
            wr_idx <= '0;
        end else if (ce_pix) begin
            if (fctl.load_pal_base) begin
                wr_idx <= '0;
            end else if (wr_en && !addr_odd) begin
                // R byte closes an entry
                wr_idx <= wr_idx + 4'd1;
            end
        end
    end

    always_ff @(posedge clk_vid) begin
        if (ce_pix && wr_en) begin
            if (addr_odd) begin
                pal_mem[wr_idx].g <= video_data[7:4];
                pal_mem[wr_idx].b <= video_data[3:0];
            end else begin
                pal_mem[wr_idx].r <= video_data[3:0];
            end
        end
    end

    assign rd_rgb = pal_mem[rd_idx];

endmodule

// File: src/shr_pixel_decoder.sv
`timescale 1ns/1ps

module shr_pixel_decoder import vgc_timing_pkg::*, vgc_color_pkg::*; (
    input  logic       clk_vid,
    input  logic       rst,
    input  logic       ce_pix,
    input  logic       shr_enable,
    input  fetch_ctl_t fctl,
    input  vpos_t      v,
    input  vbyte_t     video_data,
    input  logic [1:0] byte_phase,
    output pal_idx_t   scb_bank,
    output pal_idx_t   rd_idx,
    input  rgb12_t     rd_rgb,
    output rgb12_t     pix_rgb,
    output logic       scanline_irq
);

    vbyte_t   scb;
    vbyte_t   held_byte;
    vbyte_t   cur_byte;
    pal_idx_t nib;
    pal_idx_t last_idx;
    pal_idx_t pix_idx;
    logic     load_pix;

    // Palette bank goes straight from the bus while the SCB is being latched
    assign scb_bank = fctl.latch_scb ? video_data[3:0] : scb[3:0];

    // Address has already moved to the next byte by phase 3
    assign cur_byte = (byte_phase == 2'd3) ? held_byte : video_data;

    // 320 mode, high nibble first
    assign nib = byte_phase[1] ? cur_byte[3:0] : cur_byte[7:4];

    always_comb begin
        if (scb[7]) begin
            // 640 mode, each field picks from its own quarter
            load_pix = 1'b1;
            case (byte_phase)
                2'd0:    pix_idx = {2'b10, cur_byte[7:6]};
                2'd1:    pix_idx = {2'b11, cur_byte[5:4]};
                2'd2:    pix_idx = {2'b00, cur_byte[3:2]};
                default: pix_idx = {2'b01, cur_byte[1:0]};
            endcase
        end else begin
            // Each 320 pixel spans two strobes
            load_pix = !byte_phase[0];
            if (scb[5] && nib == 4'd0) begin
                pix_idx = last_idx;
            end else begin
                pix_idx = nib;
            end
        end
    end

    assign rd_idx = pix_idx;

    always_ff @(posedge clk_vid) begin
        if (rst) begin
            scb          <= '0;
            scanline_irq <= 1'b0;
            last_idx     <= '0;
        end else if (ce_pix) begin
            if (fctl.latch_scb) begin
                scb <= video_data;
                if (video_data[6] && shr_enable && v >= IRQ_FIRST_V && v < IRQ_END_V) begin
                    scanline_irq <= 1'b1;
                end
            end
            if (fctl.load_pal_base) begin
                scanline_irq <= 1'b0;
            end
            // Fill color restarts on each line
            if (fctl.load_line_base) begin
                last_idx <= '0;
            end else if (!scb[7] && load_pix && nib != 4'd0) begin
                last_idx <= nib;
            end
        end
    end

    always_ff @(posedge clk_vid) begin
        if (ce_pix) begin
            if (byte_phase == 2'd2) begin
                held_byte <= video_data;
            end
            if (load_pix) begin
                pix_rgb <= rd_rgb;
            end
        end
    end

endmodule

// File: src/shr_video_out.sv
`timescale 1ns/1ps

module shr_video_out import vgc_timing_pkg::*, vgc_color_pkg::*; (
    input  logic     clk_vid,
    input  logic     rst,
    input  logic     ce_pix,
    input  logic     shr_enable,
    input  hpos_t    h,
    input  vpos_t    v,
    input  pal_idx_t border_color,
    input  rgb12_t   pix_rgb,
    output rgb24_t   rgb
);

    pal_idx_t border_q;
    pal_idx_t border_sel;
    rgb12_t   border_rgb;
    rgb12_t   shown;
    logic     active;

    // Border changes take effect only at a line start
    assign border_sel = (h == '0) ? border_color : border_q;
    assign border_rgb = BORDER_PALETTE[border_sel];

    // Pixel area starts where the palette load ends
    assign active = shr_enable
                 && h >= PAL_END_H
                 && h <  PIX_END_H
                 && v >= FIRST_LINE_V
                 && v <  LAST_LINE_V;

    assign shown = active ? pix_rgb : border_rgb;

    always_ff @(posedge clk_vid) begin
        if (rst) begin
            border_q <= '0;
            rgb      <= '0;
        end else if (ce_pix) begin
            if (h == '0) begin
                border_q <= border_color;
            end
            // Nibble repeated so 4'hf maps to full scale
            rgb.r <= {shown.r, shown.r};
            rgb.g <= {shown.g, shown.g};
            rgb.b <= {shown.b, shown.b};
        end
    end

endmodule

// File: src/shr_vgc_top.sv
`timescale 1ns/1ps

module shr_vgc_top import vgc_timing_pkg::*, vgc_color_pkg::*; #(
    parameter vaddr_t BUF_BASE = 23'h012000
) (
    input  logic     clk_vid,
    input  logic     rst,
    input  logic     ce_pix,
    input  hpos_t    h,
    input  vpos_t    v,
    input  logic     shr_enable,
    input  pal_idx_t border_color,
    input  vbyte_t   video_data,
    output vaddr_t   video_addr,
    output rgb24_t   rgb,
    output logic     scanline_irq,
    output logic     vbl_irq
);

    fetch_ctl_t fctl;
    logic [1:0] byte_phase;
    pal_idx_t   scb_bank;
    pal_idx_t   rd_idx;
    rgb12_t     rd_rgb;
    rgb12_t     pix_rgb;

    // Raster decode and blanking pulse
    shr_line_sequencer shr_line_sequencer_inst (
        .clk_vid    (clk_vid),
        .rst        (rst),
        .ce_pix     (ce_pix),
        .h          (h),
        .v          (v),
        .shr_enable (shr_enable),
        .fctl       (fctl),
        .vbl_irq    (vbl_irq)
    );

    // Video memory address generation
    shr_fetch_addr #(
        .BUF_BASE (BUF_BASE)
    ) shr_fetch_addr_inst (
        .clk_vid    (clk_vid),
        .rst        (rst),
        .ce_pix     (ce_pix),
        .fctl       (fctl),
        .v          (v),
        .scb_bank   (scb_bank),
        .video_addr (video_addr),
        .byte_phase (byte_phase)
    );

    // Address parity tells GB bytes from R bytes
    shr_palette shr_palette_inst (
        .clk_vid    (clk_vid),
        .rst        (rst),
        .ce_pix     (ce_pix),
        .fctl       (fctl),
        .addr_odd   (video_addr[0]),
        .video_data (video_data),
        .rd_idx     (rd_idx),
        .rd_rgb     (rd_rgb)
    );

    shr_pixel_decoder shr_pixel_decoder_inst (
        .clk_vid      (clk_vid),
        .rst          (rst),
        .ce_pix       (ce_pix),
        .shr_enable   (shr_enable),
        .fctl         (fctl),
        .v            (v),
        .video_data   (video_data),
        .byte_phase   (byte_phase),
        .scb_bank     (scb_bank),
        .rd_idx       (rd_idx),
        .rd_rgb       (rd_rgb),
        .pix_rgb      (pix_rgb),
        .scanline_irq (scanline_irq)
    );

    shr_video_out shr_video_out_inst (
        .clk_vid      (clk_vid),
        .rst          (rst),
        .ce_pix       (ce_pix),
        .shr_enable   (shr_enable),
        .h            (h),
        .v            (v),
        .border_color (border_color),
        .pix_rgb      (pix_rgb),
        .rgb          (rgb)
    );

endmodule

// File: test/shr_vgc_chk.sv
`timescale 1ns/1ps

module shr_vgc_chk import vgc_timing_pkg::*; (
    input logic       clk_vid,
    input logic       rst,
    input logic       ce_pix,
    input hpos_t      h,
    input fetch_ctl_t fctl,
    input logic       scanline_irq,
    input logic       vbl_irq
);

    logic seen_scb_addr;

    // Set once the raster first reaches the SCB address position
    always_ff @(posedge clk_vid) begin
        if (rst) begin
            seen_scb_addr <= 1'b0;
        end else if (ce_pix && h == SCB_ADDR_H) begin
            seen_scb_addr <= 1'b1;
        end
    end

    // At most one fetch action per strobe
    assert property (@(posedge clk_vid) disable iff (rst) $onehot0(fctl))
        else $error("more than one fetch strobe high");

    assert property (@(posedge clk_vid) disable iff (rst)
        $rose(scanline_irq) |=> scanline_irq ##1 !scanline_irq)
        else $error("scanline interrupt not two strobes long");

    assert property (@(posedge clk_vid) disable iff (rst) vbl_irq |=> !vbl_irq)
        else $error("vertical blank pulse longer than one strobe");

    // Quiet outputs until the first line fetch
    assert property (@(posedge clk_vid) disable iff (rst)
        (!seen_scb_addr && h != SCB_ADDR_H) |-> (fctl == '0 && !scanline_irq && !vbl_irq))
        else $error("activity before the first SCB fetch");

endmodule

bind shr_vgc_top shr_vgc_chk shr_vgc_chk_inst (
    .clk_vid      (clk_vid),
    .rst          (rst),
    .ce_pix       (ce_pix),
    .h            (h),
    .fctl         (fctl),
    .scanline_irq (scanline_irq),
    .vbl_irq      (vbl_irq)
);

// File: test/shr_vgc_tb.sv
`timescale 1ns/1ps

module shr_vgc_tb import vgc_timing_pkg::*, vgc_color_pkg::*; ();

    localparam vaddr_t BUF_BASE = 23'h012000;
    localparam int     H_TOTAL  = 920;
    localparam int     MEM_SIZE = 32768;
    localparam int     R_BORDER = 0;
    localparam int     R_320    = 1;
    localparam int     R_640    = 2;
    localparam int     R_FILL   = 3;
    localparam int     R_VBL    = 4;

    typedef struct {
        string    name;
        int       vl;
        vbyte_t   scb;
        pal_idx_t border;
        int       rule;
    } test_row_t;

    logic     clk_vid;
    logic     rst;
    logic     ce_pix;
    hpos_t    h;
    vpos_t    v;
    logic     shr_enable;
    pal_idx_t border_color;
    vbyte_t   video_data;
    vaddr_t   video_addr;
    rgb24_t   rgb;
    logic     scanline_irq;
    logic     vbl_irq;

    vbyte_t      mem [MEM_SIZE];
    test_row_t   rows [7];
    logic [23:0] exp_rgb [640];

    // Values the DUT processed on the last edge
    hpos_t    hp;
    vpos_t    vp;
    pal_idx_t bp;
    pal_idx_t bq;
    logic     enp;
    logic     en_next;
    pal_idx_t border_next;
    int       pix_line;
    string    cur_name;
    int       test_err;
    int       err_count;
    int       failed_tests;
    int       vbl_pulses;

    // Video memory answers within the same strobe
    assign video_data = (video_addr >= BUF_BASE && video_addr < BUF_BASE + 23'(MEM_SIZE))
                      ? mem[15'(video_addr - BUF_BASE)] : 8'h00;

    shr_vgc_top #(
        .BUF_BASE (BUF_BASE)
    ) shr_vgc_top_inst (
        .clk_vid      (clk_vid),
        .rst          (rst),
        .ce_pix       (ce_pix),
        .h            (h),
        .v            (v),
        .shr_enable   (shr_enable),
        .border_color (border_color),
        .video_data   (video_data),
        .video_addr   (video_addr),
        .rgb          (rgb),
        .scanline_irq (scanline_irq),
        .vbl_irq      (vbl_irq)
    );

    initial begin
        clk_vid = 1'b0;
        forever #5 clk_vid = ~clk_vid;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Each nibble doubled into its 8-bit channel
    function automatic logic [23:0] to_rgb24(input rgb12_t c);
        return {c.r, c.r, c.g, c.g, c.b, c.b};
    endfunction

    // SCB bit 6 of the line fetched during line vl
    function automatic logic irq_for_line(input vpos_t vl, input logic en);
        int off;
        off = 'h7D00 + int'(vl) + 1 - 32;
        if (!en || vl < 9'd31 || vl >= 9'd206) begin
            return 1'b0;
        end
        return mem[off][6];
    endfunction

    task automatic report_value(input string what, input logic [23:0] exp,
                                input logic [23:0] act);
        test_err++;
        err_count++;
        $display("ERR %s %s at v=%0d h=%0d expected %h actual %h",
                 cur_name, what, vp, hp, exp, act);
    endtask

    // Expected colors of one line from the palette and pixel rules
    task automatic build_expect(input int vl);
        vbyte_t   scb;
        vbyte_t   b;
        int       pb;
        int       lb;
        pal_idx_t hi;
        pal_idx_t lo;
        pal_idx_t last;
        rgb12_t   pal [16];
        scb = mem['h7D00 + vl - 32];
        pb = 'h7E00 + 32 * int'(scb[3:0]);
        // First fetched byte is base + 1, GB on odd then R on even
        for (int k = 0; k < 16; k++) begin
            pal[k].g = mem[pb + 1 + 2 * k][7:4];
            pal[k].b = mem[pb + 1 + 2 * k][3:0];
            pal[k].r = mem[pb + 2 + 2 * k][3:0];
        end
        lb = 160 * (vl - 32);
        last = 4'd0;
        for (int n = 0; n < 160; n++) begin
            b = mem[lb + n];
            if (scb[7]) begin
                exp_rgb[4 * n]     = to_rgb24(pal[{2'b10, b[7:6]}]);
                exp_rgb[4 * n + 1] = to_rgb24(pal[{2'b11, b[5:4]}]);
                exp_rgb[4 * n + 2] = to_rgb24(pal[{2'b00, b[3:2]}]);
                exp_rgb[4 * n + 3] = to_rgb24(pal[{2'b01, b[1:0]}]);
            end else begin
                if (b[7:4] != 4'd0) begin
                    hi = b[7:4];
                    last = hi;
                end else begin
                    hi = scb[5] ? last : 4'd0;
                end
                if (b[3:0] != 4'd0) begin
                    lo = b[3:0];
                    last = lo;
                end else begin
                    lo = scb[5] ? last : 4'd0;
                end
                exp_rgb[4 * n]     = to_rgb24(pal[hi]);
                exp_rgb[4 * n + 1] = to_rgb24(pal[hi]);
                exp_rgb[4 * n + 2] = to_rgb24(pal[lo]);
                exp_rgb[4 * n + 3] = to_rgb24(pal[lo]);
            end
        end
    endtask

    task automatic check_sample();
        logic        act;
        logic        irq_exp;
        logic        vbl_exp;
        logic [23:0] exp;
        act = enp && hp >= 10'd32 && hp < 10'd672 && vp >= 9'd32 && vp < 9'd232;
        if (!act) begin
            exp = to_rgb24(BORDER_PALETTE[bq]);
            if (rgb !== exp) begin
                report_value("border rgb", exp, rgb);
            end
        end else if (int'(vp) == pix_line && hp >= 10'd33) begin
            // Pixel decoded one strobe before the output register
            exp = exp_rgb[int'(hp) - 33];
            if (rgb !== exp) begin
                report_value("pixel rgb", exp, rgb);
            end
        end
        irq_exp = (hp == 10'd910 || hp == 10'd911) && irq_for_line(vp, enp);
        if (scanline_irq !== irq_exp) begin
            report_value("scanline_irq", 24'(irq_exp), 24'(scanline_irq));
        end
        // Blank pulse on the first strobe with V at 199 or above
        vbl_exp = v >= 9'd199 && vp < 9'd199;
        if (vbl_irq) begin
            vbl_pulses++;
        end
        if (vbl_irq !== vbl_exp) begin
            report_value("vbl_irq", 24'(vbl_exp), 24'(vbl_irq));
        end
    endtask

    // One pixel strobe, inputs change on the rising edge
    task automatic tick(input hpos_t hn, input vpos_t vn);
        hp = h;
        vp = v;
        bp = border_color;
        enp = shr_enable;
        if (hp == 10'd0) begin
            bq = bp;
        end
        @(posedge clk_vid);
        h <= hn;
        v <= vn;
        shr_enable <= en_next;
        border_color <= border_next;
        @(negedge clk_vid);
        check_sample();
    endtask

    task automatic run_line(input int vl, input int change_h, input pal_idx_t change_to);
        for (int i = 0; i < H_TOTAL; i++) begin
            if (i == change_h) begin
                border_next = change_to;
            end
            tick(hpos_t'(i), vpos_t'(vl));
        end
    endtask

    task automatic run_vblank_row();
        int hcnt;
        int vcnt;
        int waited;
        hcnt = 0;
        vcnt = 197;
        waited = 0;
        while (vbl_pulses == 0 && waited < 3 * H_TOTAL) begin
            tick(hpos_t'(hcnt), vpos_t'(vcnt));
            waited++;
            hcnt++;
            if (hcnt == H_TOTAL) begin
                hcnt = 0;
                vcnt++;
            end
        end
        if (vbl_pulses == 0) begin
            $display("timeout: no vertical blank pulse within three lines");
            test_err++;
            err_count++;
        end else begin
            // Rest of the blank area must stay quiet
            while (vcnt < 201) begin
                tick(hpos_t'(hcnt), vpos_t'(vcnt));
                hcnt++;
                if (hcnt == H_TOTAL) begin
                    hcnt = 0;
                    vcnt++;
                end
            end
            if (vbl_pulses != 1) begin
                report_value("vbl pulse count", 24'd1, 24'(vbl_pulses));
            end
        end
    endtask

    initial begin
        logic [31:0] seed;
        rst = 1'b1;
        ce_pix = 1'b1;
        h = '0;
        v = '0;
        shr_enable = 1'b0;
        border_color = '0;
        en_next = 1'b0;
        border_next = '0;
        bq = '0;
        err_count = 0;
        failed_tests = 0;
        rows = '{
            '{"mode320",    40,  8'h01, 4'd2,  R_320},
            '{"mode640",    41,  8'h82, 4'd6,  R_640},
            '{"fill320",    42,  8'h23, 4'd1,  R_FILL},
            '{"irq_on",     43,  8'h44, 4'd12, R_320},
            '{"irq_v210",   210, 8'h45, 4'd7,  R_320},
            '{"border_off", 60,  8'h46, 4'd9,  R_BORDER},
            '{"vblank",     199, 8'h00, 4'd0,  R_VBL}
        };
        // Pseudo-random fill mixed with the address
        seed = 32'd98;
        for (int a = 0; a < MEM_SIZE; a++) begin
            seed = xorshift(seed);
            mem[a] = seed[7:0] ^ a[7:0] ^ {1'b0, a[14:8]};
        end
        foreach (rows[r]) begin
            if (rows[r].rule != R_VBL) begin
                mem['h7D00 + rows[r].vl - 32] = rows[r].scb;
            end
        end
        // Zero nibbles at the start of the fill line
        mem[1600] = 8'h50;
        mem[1601] = 8'h00;
        mem[1602] = 8'h07;
        mem[1603] = 8'h00;
        mem[1604] = 8'h30;

        repeat (8) @(posedge clk_vid);
        rst <= 1'b0;
        @(negedge clk_vid);

        foreach (rows[r]) begin
            cur_name = rows[r].name;
            test_err = 0;
            vbl_pulses = 0;
            en_next = rows[r].rule != R_BORDER;
            border_next = rows[r].border;
            pix_line = -1;
            if (rows[r].rule == R_320 || rows[r].rule == R_640 || rows[r].rule == R_FILL) begin
                build_expect(rows[r].vl);
                pix_line = rows[r].vl;
            end
            case (rows[r].rule)
                R_VBL: begin
                    run_vblank_row();
                end
                R_BORDER: begin
                    run_line(rows[r].vl - 1, -1, '0);
                    run_line(rows[r].vl, 300, rows[r].border ^ 4'h5);
                    run_line(rows[r].vl + 1, -1, '0);
                end
                default: begin
                    run_line(rows[r].vl - 1, -1, '0);
                    run_line(rows[r].vl, -1, '0);
                end
            endcase
            if (test_err > 0) begin
                failed_tests++;
            end
            $display("test %s done, %0d errors", cur_name, test_err);
        end

        $display("tests %0d, failed %0d, errors %0d", 7, failed_tests, err_count);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: shr_vgc_top.f
src/vgc_timing_pkg.sv
src/vgc_color_pkg.sv
src/shr_line_sequencer.sv
src/shr_fetch_addr.sv
src/shr_palette.sv
src/shr_pixel_decoder.sv
src/shr_video_out.sv
src/shr_vgc_top.sv
test/shr_vgc_chk.sv
test/shr_vgc_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the SHR video testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module shr_vgc_tb -f shr_vgc_top.f \
    -Mdir obj_dir -o shr_vgc_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/shr_vgc_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q ">>> FAIL" "$LOG"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
exit 0
